/* hdl/id_pkg.sv */
// word, instruction and register index types for the decode stage
// RV32I major opcodes, operand select codes and exception bit positions
package id_pkg;

    // ************************************************************************
    // widths
    // ************************************************************************
    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int EXC_W      = 4;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [ILEN-1:0]       inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [EXC_W-1:0]      exc_t;

    // x0 is hardwired to zero
    localparam reg_addr_t ZERO_REG = 5'd0;

    // exception vector bit positions
    localparam int EXC_MRET    = 0;
    localparam int EXC_ECALL   = 1;
    localparam int EXC_EBREAK  = 2;
    localparam int EXC_ILLEGAL = 3;

    // ************************************************************************
    // major opcodes, inst[6:0]
    // ************************************************************************
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // first ALU operand source
    typedef enum logic [1:0] {
        OP1_ZERO = 2'd0,
        OP1_RS1  = 2'd1,
        OP1_PC   = 2'd2,
        OP1_UIMM = 2'd3
    } op1_sel_e;

    // second ALU operand source
    typedef enum logic [2:0] {
        OP2_ZERO  = 3'd0,
        OP2_RS2   = 3'd1,
        OP2_IMM_I = 3'd2,
        OP2_IMM_S = 3'd3,
        OP2_SHAMT = 3'd4,
        OP2_FOUR  = 3'd5,
        OP2_UIMM  = 3'd6
    } op2_sel_e;

endpackage

/* hdl/id_decoder.sv */
// combinational RV32I decoder: read requests, operand assembly,
// write enable and exception vector
`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
    input  inst_t     inst_i,
    input  xlen_t     instaddr_i,
    // forwarded source values
    input  xlen_t     rs1_val_i,
    input  xlen_t     rs2_val_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output logic      rs1_read_o,
    output logic      rs2_read_o,
    output xlen_t     op1_o,
    output xlen_t     op2_o,
    output logic      regs_wen_o,
    output reg_addr_t rd_addr_o,
    output exc_t      exception_o
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    localparam inst_t INST_ECALL  = 32'h0000_0073;
    localparam inst_t INST_EBREAK = 32'h0010_0073;
    localparam inst_t INST_MRET   = 32'h3020_0073;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    xlen_t       imm_i;
    xlen_t       imm_s;
    xlen_t       imm_u;
    xlen_t       shamt;
    op1_sel_e    op1_sel;
    op2_sel_e    op2_sel;
    logic        illegal;
    logic        wen;
    logic        rs1_rd;
    logic        rs2_rd;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // immediates
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u = {inst_i[31:12], 12'h000};
    assign shamt = {27'd0, inst_i[24:20]};

    // ************************************************************************
    // control decode
    // ************************************************************************
    always_comb begin
        rs1_rd      = 1'b0;
        rs2_rd      = 1'b0;
        op1_sel     = OP1_ZERO;
        op2_sel     = OP2_ZERO;
        wen         = 1'b0;
        illegal     = 1'b0;
        exception_o = '0;
        case (opcode)
            OPC_OP_IMM: begin
                rs1_rd  = 1'b1;
                op1_sel = OP1_RS1;
                op2_sel = OP2_IMM_I;
                wen     = 1'b1;
                // shifts carry funct7 in the upper immediate bits
                if (funct3 == 3'b001) begin
                    op2_sel = OP2_SHAMT;
                    illegal = (funct7 != F7_BASE);
                end else if (funct3 == 3'b101) begin
                    op2_sel = OP2_SHAMT;
                    illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                end
            end
            OPC_OP: begin
                rs1_rd  = 1'b1;
                rs2_rd  = 1'b1;
                op1_sel = OP1_RS1;
                op2_sel = OP2_RS2;
                wen     = 1'b1;
                // alternate funct7 only for sub and sra
                if (funct7 == F7_ALT) begin
                    illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else begin
                    illegal = (funct7 != F7_BASE);
                end
            end
            OPC_JAL: begin
                op1_sel = OP1_PC;
                op2_sel = OP2_FOUR;
                wen     = 1'b1;
            end
            OPC_JALR: begin
                rs1_rd  = 1'b1;
                op1_sel = OP1_PC;
                op2_sel = OP2_FOUR;
                wen     = 1'b1;
                illegal = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                rs1_rd  = 1'b1;
                rs2_rd  = 1'b1;
                op1_sel = OP1_RS1;
                op2_sel = OP2_RS2;
                illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            OPC_LUI: begin
                op1_sel = OP1_UIMM;
                wen     = 1'b1;
            end
            OPC_AUIPC: begin
                op1_sel = OP1_PC;
                op2_sel = OP2_UIMM;
                wen     = 1'b1;
            end
            OPC_LOAD: begin
                rs1_rd  = 1'b1;
                op1_sel = OP1_RS1;
                op2_sel = OP2_IMM_I;
                wen     = 1'b1;
                // lb lh lw lbu lhu
                illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OPC_STORE: begin
                rs1_rd  = 1'b1;
                rs2_rd  = 1'b1;
                op1_sel = OP1_RS1;
                op2_sel = OP2_IMM_S;
                illegal = (funct3[2] == 1'b1) || (funct3 == 3'b011);
            end
            OPC_SYSTEM: begin
                if (inst_i == INST_ECALL) begin
                    exception_o[EXC_ECALL] = 1'b1;
                end else if (inst_i == INST_EBREAK) begin
                    exception_o[EXC_EBREAK] = 1'b1;
                end else if (inst_i == INST_MRET) begin
                    exception_o[EXC_MRET] = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
        // an illegal instruction requests nothing and writes nothing
        if (illegal) begin
            rs1_rd                   = 1'b0;
            rs2_rd                   = 1'b0;
            op1_sel                  = OP1_ZERO;
            op2_sel                  = OP2_ZERO;
            wen                      = 1'b0;
            exception_o[EXC_ILLEGAL] = 1'b1;
        end
    end

    assign rs1_read_o = rs1_rd;
    assign rs2_read_o = rs2_rd;
    assign rs1_addr_o = rs1_rd ? inst_i[19:15] : ZERO_REG;
    assign rs2_addr_o = rs2_rd ? inst_i[24:20] : ZERO_REG;
    assign regs_wen_o = wen;
    assign rd_addr_o  = wen ? inst_i[11:7] : ZERO_REG;

    // ************************************************************************
    // operand muxes
    // ************************************************************************
    always_comb begin
        case (op1_sel)
            OP1_RS1:  op1_o = rs1_val_i;
            OP1_PC:   op1_o = instaddr_i;
            OP1_UIMM: op1_o = imm_u;
            default:  op1_o = '0;
        endcase
    end

    always_comb begin
        case (op2_sel)
            OP2_RS2:   op2_o = rs2_val_i;
            OP2_IMM_I: op2_o = imm_i;
            OP2_IMM_S: op2_o = imm_s;
            OP2_SHAMT: op2_o = shamt;
            OP2_FOUR:  op2_o = 32'd4;
            OP2_UIMM:  op2_o = imm_u;
            default:   op2_o = '0;
        endcase
    end

endmodule

/* hdl/id_operand_fwd.sv */
// forwarding mux and load-use check for one source operand
`timescale 1ns/1ps

module id_operand_fwd import id_pkg::*; (
    input  reg_addr_t rs_addr_i,
    input  logic      rs_read_i,
    input  xlen_t     rf_data_i,
    // EX stage write port
    input  inst_t     ex_inst_i,
    input  logic      ex_wen_i,
    input  reg_addr_t ex_wr_addr_i,
    input  xlen_t     ex_wr_data_i,
    // MEM stage write port
    input  logic      mem_wen_i,
    input  reg_addr_t mem_wr_addr_i,
    input  xlen_t     mem_wr_data_i,
    output xlen_t     rs_val_o,
    output logic      load_hazard_o
);

    logic ex_hit;
    logic mem_hit;
    logic ex_is_load;

    // x0 never forwards
    assign ex_hit  = rs_read_i && ex_wen_i && (rs_addr_i == ex_wr_addr_i)
                     && (ex_wr_addr_i != ZERO_REG);
    assign mem_hit = rs_read_i && mem_wen_i && (rs_addr_i == mem_wr_addr_i)
                     && (mem_wr_addr_i != ZERO_REG);

    assign ex_is_load = (opcode_e'(ex_inst_i[6:0]) == OPC_LOAD);

    // youngest producer wins
    always_comb begin
        if (ex_hit) begin
            rs_val_o = ex_wr_data_i;
        end else if (mem_hit) begin
            rs_val_o = mem_wr_data_i;
        end else if (rs_read_i) begin
            rs_val_o = rf_data_i;
        end else begin
            rs_val_o = '0;
        end
    end

    // load data not ready until after MEM
    assign load_hazard_o = ex_hit && ex_is_load;

endmodule

/* hdl/id_ex_reg.sv */
// ID/EX pipeline register with bubble insertion on a load-use hold
`timescale 1ns/1ps

module id_ex_reg import id_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      rs1_hazard_i,
    input  logic      rs2_hazard_i,
    input  inst_t     inst_i,
    input  xlen_t     instaddr_i,
    input  xlen_t     op1_i,
    input  xlen_t     op2_i,
    input  xlen_t     rs1_val_i,
    input  xlen_t     rs2_val_i,
    input  logic      regs_wen_i,
    input  reg_addr_t rd_addr_i,
    input  exc_t      exception_i,
    output logic      hold_flag_o,
    output inst_t     inst_o,
    output xlen_t     instaddr_o,
    output xlen_t     op1_o,
    output xlen_t     op2_o,
    output xlen_t     id_rs1_data_o,
    output xlen_t     id_rs2_data_o,
    output logic      regs_wen_o,
    output reg_addr_t rd_addr_o,
    output exc_t      exception_o
);

    assign hold_flag_o = rs1_hazard_i | rs2_hazard_i;

    // ************************************************************************
    // stage register
    // ************************************************************************
    // a held instruction leaves a bubble behind, it is replayed next cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || hold_flag_o) begin
            inst_o        <= '0;
            instaddr_o    <= '0;
            op1_o         <= '0;
            op2_o         <= '0;
            id_rs1_data_o <= '0;
            id_rs2_data_o <= '0;
            regs_wen_o    <= 1'b0;
            rd_addr_o     <= ZERO_REG;
            exception_o   <= '0;
        end else begin
            inst_o        <= inst_i;
            instaddr_o    <= instaddr_i;
            op1_o         <= op1_i;
            op2_o         <= op2_i;
            id_rs1_data_o <= rs1_val_i;
            id_rs2_data_o <= rs2_val_i;
            regs_wen_o    <= regs_wen_i;
            rd_addr_o     <= rd_addr_i;
            exception_o   <= exception_i;
        end
    end

endmodule

/* hdl/id_stage_top.sv */
// decode stage top: decoder, rs1/rs2 forwarding units and the ID/EX register
`timescale 1ns/1ps

module id_stage_top import id_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // from fetch
    input  inst_t     inst_i,
    input  xlen_t     instaddr_i,
    // register file
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output logic      rs1_read_o,
    output logic      rs2_read_o,
    // EX stage
    input  inst_t     ex_inst_i,
    input  logic      ex_wen_i,
    input  reg_addr_t ex_wr_addr_i,
    input  xlen_t     ex_wr_data_i,
    // MEM stage
    input  logic      mem_wen_i,
    input  reg_addr_t mem_wr_addr_i,
    input  xlen_t     mem_wr_data_i,
    // pipeline control
    output logic      hold_flag_o,
    // to EX
    output inst_t     inst_o,
    output xlen_t     instaddr_o,
    output xlen_t     op1_o,
    output xlen_t     op2_o,
    output xlen_t     id_rs1_data_o,
    output xlen_t     id_rs2_data_o,
    output logic      regs_wen_o,
    output reg_addr_t rd_addr_o,
    output exc_t      exception_o
);

    xlen_t     rs1_val;
    xlen_t     rs2_val;
    logic      rs1_hazard;
    logic      rs2_hazard;
    xlen_t     dec_op1;
    xlen_t     dec_op2;
    logic      dec_wen;
    reg_addr_t dec_rd_addr;
    exc_t      dec_exc;

    id_decoder u_decoder (
        .inst_i      (inst_i),
        .instaddr_i  (instaddr_i),
        .rs1_val_i   (rs1_val),
        .rs2_val_i   (rs2_val),
        .rs1_addr_o  (rs1_addr_o),
        .rs2_addr_o  (rs2_addr_o),
        .rs1_read_o  (rs1_read_o),
        .rs2_read_o  (rs2_read_o),
        .op1_o       (dec_op1),
        .op2_o       (dec_op2),
        .regs_wen_o  (dec_wen),
        .rd_addr_o   (dec_rd_addr),
        .exception_o (dec_exc)
    );

    id_operand_fwd u_fwd_rs1 (
        .rs_addr_i     (rs1_addr_o),
        .rs_read_i     (rs1_read_o),
        .rf_data_i     (rs1_data_i),
        .ex_inst_i     (ex_inst_i),
        .ex_wen_i      (ex_wen_i),
        .ex_wr_addr_i  (ex_wr_addr_i),
        .ex_wr_data_i  (ex_wr_data_i),
        .mem_wen_i     (mem_wen_i),
        .mem_wr_addr_i (mem_wr_addr_i),
        .mem_wr_data_i (mem_wr_data_i),
        .rs_val_o      (rs1_val),
        .load_hazard_o (rs1_hazard)
    );

    id_operand_fwd u_fwd_rs2 (
        .rs_addr_i     (rs2_addr_o),
        .rs_read_i     (rs2_read_o),
        .rf_data_i     (rs2_data_i),
        .ex_inst_i     (ex_inst_i),
        .ex_wen_i      (ex_wen_i),
        .ex_wr_addr_i  (ex_wr_addr_i),
        .ex_wr_data_i  (ex_wr_data_i),
        .mem_wen_i     (mem_wen_i),
        .mem_wr_addr_i (mem_wr_addr_i),
        .mem_wr_data_i (mem_wr_data_i),
        .rs_val_o      (rs2_val),
        .load_hazard_o (rs2_hazard)
    );

    id_ex_reg u_id_ex_reg (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rs1_hazard_i  (rs1_hazard),
        .rs2_hazard_i  (rs2_hazard),
        .inst_i        (inst_i),
        .instaddr_i    (instaddr_i),
        .op1_i         (dec_op1),
        .op2_i         (dec_op2),
        .rs1_val_i     (rs1_val),
        .rs2_val_i     (rs2_val),
        .regs_wen_i    (dec_wen),
        .rd_addr_i     (dec_rd_addr),
        .exception_i   (dec_exc),
        .hold_flag_o   (hold_flag_o),
        .inst_o        (inst_o),
        .instaddr_o    (instaddr_o),
        .op1_o         (op1_o),
        .op2_o         (op2_o),
        .id_rs1_data_o (id_rs1_data_o),
        .id_rs2_data_o (id_rs2_data_o),
        .regs_wen_o    (regs_wen_o),
        .rd_addr_o     (rd_addr_o),
        .exception_o   (exception_o)
    );

endmodule

/* tests/id_stage_checker.sv */
// concurrent assertions on the decode stage ports, bound into id_stage_top
`timescale 1ns/1ps

module id_stage_checker import id_pkg::*; (
    input logic      clk_i,
    input logic      rst_n_i,
    input logic      hold_flag_o,
    input inst_t     ex_inst_i,
    input inst_t     inst_o,
    input xlen_t     instaddr_o,
    input xlen_t     op1_o,
    input xlen_t     op2_o,
    input xlen_t     id_rs1_data_o,
    input xlen_t     id_rs2_data_o,
    input logic      regs_wen_o,
    input reg_addr_t rd_addr_o,
    input exc_t      exception_o
);

    logic regs_zero;

    assign regs_zero = (inst_o == '0) && (instaddr_o == '0) && (op1_o == '0)
                       && (op2_o == '0) && (id_rs1_data_o == '0)
                       && (id_rs2_data_o == '0) && !regs_wen_o
                       && (rd_addr_o == ZERO_REG) && (exception_o == '0);

    // a trapping instruction never writes back
    exc_blocks_wen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (exception_o != '0) |-> !regs_wen_o)
        else $error("regs_wen_o set together with exception %h", exception_o);

    hold_gives_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hold_flag_o |=> regs_zero)
        else $error("ID/EX not cleared after a hold");

    // only a load in EX can stall decode
    hold_needs_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hold_flag_o |-> (ex_inst_i[6:0] == OPC_LOAD))
        else $error("hold without a load in EX, ex_inst %h", ex_inst_i);

    reset_clears: assert property (@(posedge clk_i)
        !rst_n_i |=> regs_zero)
        else $error("ID/EX not cleared by reset");

endmodule

bind id_stage_top id_stage_checker u_checker (.*);

/* tests/tb_id_stage.sv */
// decode stage testbench reading cases from a file and driving on the falling edge
// hold and read requests checked before each edge and the ID/EX outputs after it
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int MAX_CASES  = 64;

    logic      clk_i;
    logic      rst_n_i;
    inst_t     inst_i;
    xlen_t     instaddr_i;
    xlen_t     rs1_data_i;
    xlen_t     rs2_data_i;
    reg_addr_t rs1_addr_o;
    reg_addr_t rs2_addr_o;
    logic      rs1_read_o;
    logic      rs2_read_o;
    inst_t     ex_inst_i;
    logic      ex_wen_i;
    reg_addr_t ex_wr_addr_i;
    xlen_t     ex_wr_data_i;
    logic      mem_wen_i;
    reg_addr_t mem_wr_addr_i;
    xlen_t     mem_wr_data_i;
    logic      hold_flag_o;
    inst_t     inst_o;
    xlen_t     instaddr_o;
    xlen_t     op1_o;
    xlen_t     op2_o;
    xlen_t     id_rs1_data_o;
    xlen_t     id_rs2_data_o;
    logic      regs_wen_o;
    reg_addr_t rd_addr_o;
    exc_t      exception_o;

    // one row per case with columns in case file order
    logic [31:0] cases [0:MAX_CASES-1][0:14];
    int          num_cases = 0;
    int          err_cnt   = 0;
    int          pass_cnt  = 0;
    int          fail_cnt  = 0;
    int          cycle_cnt = 0;

    id_stage_top uut (.*);

    // register file model where every register reads as A0000000 plus its index
    assign rs1_data_i = 32'hA000_0000 + {27'd0, rs1_addr_o};
    assign rs2_data_i = 32'hA000_0000 + {27'd0, rs2_addr_o};

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ************************************************************************
    // watchdog allows four cycles per case plus reset margin
    // ************************************************************************
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > num_cases * 4 + 20) begin
            $display("timeout: run exceeded %0d clock cycles", num_cases * 4 + 20);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_exc(input string name, input exc_t exp, input exc_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            err_cnt++;
        end
    endtask

    // source reads per major opcode, bit 0 for rs1 and bit 1 for rs2
    function automatic logic [1:0] reads_for(input inst_t inst, input exc_t exc);
        logic [1:0] rd_en;
        case (inst[6:0])
            OPC_OP, OPC_BRANCH, OPC_STORE:   rd_en = 2'b11;
            OPC_OP_IMM, OPC_JALR, OPC_LOAD:  rd_en = 2'b01;
            default:                         rd_en = 2'b00;
        endcase
        // an illegal instruction requests nothing
        if (exc[EXC_ILLEGAL]) begin
            rd_en = 2'b00;
        end
        return rd_en;
    endfunction

    // operand value seen by decode: register file, overridden by MEM, then by EX
    function automatic xlen_t source_value(input int n, input logic rd_en,
                                           input reg_addr_t addr);
        xlen_t val;
        val = '0;
        if (rd_en) begin
            val = 32'hA000_0000 + {27'd0, addr};
            if (cases[n][6][0] && cases[n][7][4:0] == addr && addr != ZERO_REG) begin
                val = cases[n][8];
            end
            if (cases[n][3][0] && cases[n][4][4:0] == addr && addr != ZERO_REG) begin
                val = cases[n][5];
            end
        end
        return val;
    endfunction

    task automatic expect_registered(input inst_t e_inst, input xlen_t e_pc,
                                     input xlen_t e_op1, input xlen_t e_op2,
                                     input xlen_t e_rs1, input xlen_t e_rs2,
                                     input logic e_wen, input reg_addr_t e_rd,
                                     input exc_t e_exc);
        check_word("inst_o", e_inst, inst_o);
        check_word("instaddr_o", e_pc, instaddr_o);
        check_word("op1_o", e_op1, op1_o);
        check_word("op2_o", e_op2, op2_o);
        check_word("id_rs1_data_o", e_rs1, id_rs1_data_o);
        check_word("id_rs2_data_o", e_rs2, id_rs2_data_o);
        check_bit("regs_wen_o", e_wen, regs_wen_o);
        check_addr("rd_addr_o", e_rd, rd_addr_o);
        check_exc("exception_o", e_exc, exception_o);
    endtask

    task automatic report_test(input string label, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%s: pass", label);
        end else begin
            fail_cnt++;
            $display("%s: fail", label);
        end
    endtask

    task automatic read_cases();
        int    fd;
        int    n;
        string line;
        fd = $fopen("tests/id_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_cases < MAX_CASES) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.substr(0, 1) == "//") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            cases[num_cases][0], cases[num_cases][1], cases[num_cases][2],
                            cases[num_cases][3], cases[num_cases][4], cases[num_cases][5],
                            cases[num_cases][6], cases[num_cases][7], cases[num_cases][8],
                            cases[num_cases][9], cases[num_cases][10], cases[num_cases][11],
                            cases[num_cases][12], cases[num_cases][13], cases[num_cases][14]);
                if (n == 15) begin
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_case(input int n);
        logic       exp_hold;
        logic [1:0] exp_rd;
        reg_addr_t  exp_rs1;
        reg_addr_t  exp_rs2;
        int         errs_before;
        exp_hold    = cases[n][9][0];
        exp_rd      = reads_for(cases[n][0], cases[n][14][3:0]);
        exp_rs1     = exp_rd[0] ? cases[n][0][19:15] : ZERO_REG;
        exp_rs2     = exp_rd[1] ? cases[n][0][24:20] : ZERO_REG;
        errs_before = err_cnt;
        @(negedge clk_i);
        inst_i        = cases[n][0];
        instaddr_i    = cases[n][1];
        ex_inst_i     = cases[n][2];
        ex_wen_i      = cases[n][3][0];
        ex_wr_addr_i  = cases[n][4][4:0];
        ex_wr_data_i  = cases[n][5];
        mem_wen_i     = cases[n][6][0];
        mem_wr_addr_i = cases[n][7][4:0];
        mem_wr_data_i = cases[n][8];
        // hold and read requests are combinational so sample them before the edge
        #1;
        check_bit("hold_flag_o", exp_hold, hold_flag_o);
        check_bit("rs1_read_o", exp_rd[0], rs1_read_o);
        check_bit("rs2_read_o", exp_rd[1], rs2_read_o);
        check_addr("rs1_addr_o", exp_rs1, rs1_addr_o);
        check_addr("rs2_addr_o", exp_rs2, rs2_addr_o);
        @(negedge clk_i);
        // held instruction leaves an all-zero bubble
        expect_registered(exp_hold ? '0 : cases[n][0], exp_hold ? '0 : cases[n][1],
                          cases[n][10], cases[n][11],
                          exp_hold ? '0 : source_value(n, exp_rd[0], exp_rs1),
                          exp_hold ? '0 : source_value(n, exp_rd[1], exp_rs2),
                          cases[n][12][0], cases[n][13][4:0], cases[n][14][3:0]);
        report_test($sformatf("case %0d inst %h", n, cases[n][0]), errs_before);
    endtask

    // ************************************************************************
    // main sequence
    // ************************************************************************
    initial begin
        int errs_before;
        rst_n_i       = 1'b0;
        inst_i        = 32'h0000_0013;
        instaddr_i    = '0;
        ex_inst_i     = 32'h0000_0013;
        ex_wen_i      = 1'b0;
        ex_wr_addr_i  = ZERO_REG;
        ex_wr_data_i  = '0;
        mem_wen_i     = 1'b0;
        mem_wr_addr_i = ZERO_REG;
        mem_wr_data_i = '0;
        read_cases();
        errs_before = err_cnt;
        repeat (3) begin
            @(negedge clk_i);
            expect_registered('0, '0, '0, '0, '0, '0, 1'b0, ZERO_REG, '0);
        end
        rst_n_i = 1'b1;
        report_test("reset", errs_before);
        for (int n = 0; n < num_cases; n++) begin
            run_case(n);
        end
        if (num_cases == 0) begin
            $display("no test case could be read from tests/id_cases.txt");
        end
        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && num_cases > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tests/id_cases.txt */
// inst pc ex_inst ex_wen ex_addr ex_data mem_wen mem_addr mem_data, then expected:
// hold op1 op2 regs_wen rd_addr exception (all hex)
FFD30293 00001000 00000013 0 00 00000000 0 00 00000000 0 A0000006 FFFFFFFD 1 05 0
00D41393 00001004 00000013 0 00 00000000 0 00 00000000 0 A0000008 0000000D 1 07 0
40C58533 00001008 00000013 0 00 00000000 0 00 00000000 0 A000000B A000000C 1 0A 0
00C58533 0000100C 00000033 1 0B 11111111 1 0B 22222222 0 11111111 A000000C 1 0A 0
00C58533 00001010 00000013 0 00 00000000 1 0C 33333333 0 A000000B 33333333 1 0A 0
00C00533 00001014 00000033 1 00 44444444 0 00 00000000 0 A0000000 A000000C 1 0A 0
00C58533 00001018 00012583 1 0B 55555555 0 00 00000000 1 00000000 00000000 0 00 0
00C58533 00001018 00000033 1 0B 55555555 0 00 00000000 0 55555555 A000000C 1 0A 0
008000EF 00002000 00000013 0 00 00000000 0 00 00000000 0 00002000 00000004 1 01 0
000280E7 00002010 00000013 0 00 00000000 0 00 00000000 0 00002010 00000004 1 01 0
123451B7 00002020 00000013 0 00 00000000 0 00 00000000 0 12345000 00000000 1 03 0
ABCDE217 00003000 00000013 0 00 00000000 0 00 00000000 0 00003000 ABCDE000 1 04 0
FEC5AC23 00003004 00000013 0 00 00000000 0 00 00000000 0 A000000B FFFFFFF8 0 00 0
0000007F 00003008 00000013 0 00 00000000 0 00 00000000 0 00000000 00000000 0 00 8
02C58533 0000300C 00000013 0 00 00000000 0 00 00000000 0 00000000 00000000 0 00 8
300110F3 00003010 00000013 0 00 00000000 0 00 00000000 0 00000000 00000000 0 00 8
00000073 00003014 00000013 0 00 00000000 0 00 00000000 0 00000000 00000000 0 00 2
00100073 00003018 00000013 0 00 00000000 0 00 00000000 0 00000000 00000000 0 00 4
30200073 0000301C 00000013 0 00 00000000 0 00 00000000 0 00000000 00000000 0 00 1

/* compile.f */
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_operand_fwd.sv
hdl/id_ex_reg.sv
hdl/id_stage_top.sv
tests/id_stage_checker.sv
tests/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - hdl/id_pkg.sv
  - hdl/id_decoder.sv
  - hdl/id_operand_fwd.sv
  - hdl/id_ex_reg.sv
  - hdl/id_stage_top.sv
  - target: test
    files:
      - tests/id_stage_checker.sv
      - tests/tb_id_stage.sv
